// File: vlog.f
edge_pkg.sv
scan_tracker.sv
window_builder.sv
sobel_kernel.sv
edge_detect_top.sv
edge_properties.sv
edge_checker.sv
tb_edge_detect.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_edge_detect -f vlog.f -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "test run failed"; exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
		echo "test run ended without a pass line"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tb_edge_detect.sv
// testbench for the edge detection subsystem that streams frames and runs the test sequence
`timescale 1ns/1ps

module tb_edge_detect;
    import edge_pkg::*;

    localparam int line_gap     = 8;
    localparam int vsync_cycles = 6;  // 2 high, 4 low
    localparam int frame_cycles = vsync_cycles + 240 * (320 + line_gap);
    localparam int cycle_limit  = 6 * frame_cycles + 2000;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        vsync;
    logic        active_area;
    rgb444_t     pixel;
    logic        edge_valid;
    edge_pixel_t edge_out;

    rgb444_t     image [frame_height][frame_width];
    logic [31:0] rng_state;
    logic        test_start;
    logic        test_end;
    int          last_row;
    int          skip_lo;
    int          skip_hi;
    int          out_count;
    int          err_count;
    int          total_errors;
    int          total_outputs;
    int          tests_run;
    int          cycles;

    edge_detect_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .vsync       (vsync),
        .active_area (active_area),
        .pixel       (pixel),
        .edge_valid  (edge_valid),
        .edge_out    (edge_out)
    );

    edge_checker chk_i (
        .clk        (clk),
        .edge_valid (edge_valid),
        .edge_out   (edge_out),
        .image      (image),
        .test_start (test_start),
        .test_end   (test_end),
        .last_row   (last_row),
        .skip_lo    (skip_lo),
        .skip_hi    (skip_hi),
        .out_count  (out_count),
        .err_count  (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic fill_image(input int kind);
        for (int y = 0; y < 240; y++) begin
            for (int x = 0; x < 320; x++) begin
                case (kind)
                    0: image[y][x] = 12'h6a3;
                    1: image[y][x] = (x < 160) ? 12'h000 : 12'hfff;  // step at column 160
                    default: begin
                        rng_state = xorshift32(rng_state);
                        image[y][x] = rng_state[11:0];
                    end
                endcase
            end
        end
    endtask

    task automatic drive_frame(input int lines, input int en_lo, input int en_hi);
        vsync = 1'b1;
        repeat (2) next_cycle();
        vsync = 1'b0;
        repeat (vsync_cycles - 2) next_cycle();
        for (int y = 0; y < lines; y++) begin
            enable = !(y >= en_lo && y <= en_hi);
            for (int x = 0; x < 320; x++) begin
                active_area = 1'b1;
                pixel       = image[y][x];
                next_cycle();
            end
            active_area = 1'b0;
            pixel       = '0;
            repeat (line_gap) next_cycle();  // long enough to drain the pipeline
        end
        enable = 1'b1;
    endtask

    task automatic run_test(input string name, input int kind, input int lines,
                            input int en_lo, input int en_hi);
        fill_image(kind);
        last_row = (lines >= 240) ? 238 : lines - 2;
        // row r is finished while line r+1 streams in
        skip_lo  = en_lo - 1;
        skip_hi  = en_hi - 1;
        test_start = 1'b1;
        next_cycle();
        test_start = 1'b0;
        drive_frame(lines, en_lo, en_hi);
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
        next_cycle();
        tests_run++;
        total_errors  += err_count;
        total_outputs += out_count;
        $display("test %0d %s: %0d outputs, %0d errors", tests_run, name, out_count, err_count);
    endtask

    initial begin
        rst_n         = 1'b0;
        enable        = 1'b1;
        vsync         = 1'b0;
        active_area   = 1'b0;
        pixel         = '0;
        test_start    = 1'b0;
        test_end      = 1'b0;
        last_row      = 238;
        skip_lo       = -2;
        skip_hi       = -2;
        rng_state     = 32'hbdd8929e;
        total_errors  = 0;
        total_outputs = 0;
        tests_run     = 0;
        cycles        = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        run_test("uniform frame", 0, 240, -1, -1);
        run_test("vertical step", 1, 240, -1, -1);
        run_test("random frame", 2, 240, -1, -1);
        run_test("enable low on lines 100 to 149", 2, 240, 100, 149);
        run_test("frame cut by vsync at line 60", 2, 60, -1, -1);
        run_test("random frame after the cut", 2, 240, -1, -1);

        $display("summary: %0d tests, %0d outputs, %0d errors, %0d assertion failures",
                 tests_run, total_outputs, total_errors, dut_i.props_i.fail_count);
        if (total_errors == 0 && dut_i.props_i.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: edge_checker.sv
// edge checker, reference sobel model compared against every DUT output
`timescale 1ns/1ps

module edge_checker (
    input  logic                  clk,
    input  logic                  edge_valid,
    input  edge_pkg::edge_pixel_t edge_out,
    input  edge_pkg::rgb444_t     image [edge_pkg::frame_height][edge_pkg::frame_width],
    input  logic                  test_start,  // clears the per-test state
    input  logic                  test_end,    // frame finished, check the count
    input  int                    last_row,    // last row that gives outputs
    input  int                    skip_lo,     // rows silenced by enable
    input  int                    skip_hi,
    output int                    out_count,
    output int                    err_count
);
    import edge_pkg::*;

    int exp_x;
    int exp_y;
    int exp_val;

    function automatic int gray_of(int x, int y);
        int p;
        p = int'(image[y][x]);
        return 4 * (((p >> 8) & 15) + 2 * ((p >> 4) & 15) + (p & 15));
    endfunction

    // expected output for the centre pixel (x, y)
    function automatic int ref_edge(int x, int y);
        int gx;
        int gy;
        int mag;
        gx = gray_of(x + 1, y - 1) + 2 * gray_of(x + 1, y) + gray_of(x + 1, y + 1)
           - gray_of(x - 1, y - 1) - 2 * gray_of(x - 1, y) - gray_of(x - 1, y + 1);
        gy = gray_of(x - 1, y + 1) + 2 * gray_of(x, y + 1) + gray_of(x + 1, y + 1)
           - gray_of(x - 1, y - 1) - 2 * gray_of(x, y - 1) - gray_of(x + 1, y - 1);
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        if (mag > int'(strong_threshold)) begin
            return 255;
        end else if (mag > int'(noise_threshold)) begin
            return mag;
        end
        return 0;
    endfunction

    function automatic int next_row(int y);
        int r;
        r = y + 1;
        while (r >= skip_lo && r <= skip_hi) begin
            r++;
        end
        return r;
    endfunction

    function automatic int expected_count();
        int rows;
        rows = 0;
        for (int y = 1; y <= last_row; y++) begin
            if (y < skip_lo || y > skip_hi) begin
                rows++;
            end
        end
        return rows * (int'(frame_width) - 2);
    endfunction

    // outputs are registered, so mid-cycle they are settled
    always @(negedge clk) begin
        if (test_start) begin
            exp_x     = 1;
            exp_y     = next_row(0);
            out_count = 0;
            err_count = 0;
        end
        if (edge_valid) begin
            out_count++;
            if (exp_y > last_row) begin
                $display("output at row %0d after the last expected row %0d",
                         edge_out.pos.y, last_row);
                err_count++;
            end else begin
                exp_val = ref_edge(exp_x, exp_y);
                if (int'(edge_out.pos.x) != exp_x || int'(edge_out.pos.y) != exp_y) begin
                    $display("MISMATCH edge_out.pos expected x=%h y=%h got x=%h y=%h",
                             exp_x[8:0], exp_y[8:0], edge_out.pos.x, edge_out.pos.y);
                    err_count++;
                end
                if (int'(edge_out.value) != exp_val) begin
                    $display("MISMATCH edge_out.value at (%0d,%0d) expected %h got %h",
                             exp_x, exp_y, exp_val[7:0], edge_out.value);
                    err_count++;
                end
                // only 0, 255 and the mid band 13..25 can appear
                if (edge_out.value != 8'd0 && edge_out.value != 8'd255 &&
                    (edge_out.value < 8'd13 || edge_out.value > 8'd25)) begin
                    $display("value %0d at (%0d,%0d) is outside the output set",
                             edge_out.value, exp_x, exp_y);
                    err_count++;
                end
            end
            exp_x++;
            if (exp_x > int'(frame_width) - 2) begin
                exp_x = 1;
                exp_y = next_row(exp_y);
            end
        end
        if (test_end && out_count != expected_count()) begin
            $display("wrong number of outputs in the frame, expected %0d but got %0d",
                     expected_count(), out_count);
            err_count++;
        end
    end

endmodule

// File: edge_properties.sv
// edge output properties checking quiet reset, interior positions and enable gating
`timescale 1ns/1ps

module edge_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  enable,
    input logic                  edge_valid,
    input edge_pkg::edge_pixel_t edge_out
);
    import edge_pkg::*;

    int fail_count = 0;  // failed assertions so far

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !edge_valid)
        else begin
            $error("edge_valid high while reset is held");
            fail_count++;
        end

    // border pixels never produce a result
    a_interior_only: assert property (@(posedge clk) disable iff (!rst_n)
        edge_valid |-> (edge_out.pos.x >= 9'd1) && (edge_out.pos.x <= frame_width - 9'd2) &&
                       (edge_out.pos.y >= 9'd1) && (edge_out.pos.y <= frame_height - 9'd2))
        else begin
            $error("edge_valid with a border position x=%0d y=%0d",
                   edge_out.pos.x, edge_out.pos.y);
            fail_count++;
        end

    a_enable_gates: assert property (@(posedge clk) disable iff (!rst_n)
        edge_valid |-> $past(enable))  // enable sampled in kernel stage 2
        else begin
            $error("edge_valid without enable in the previous cycle");
            fail_count++;
        end

endmodule

bind edge_detect_top edge_properties props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (enable),
    .edge_valid (edge_valid),
    .edge_out   (edge_out)
);

// File: edge_detect_top.sv
// edge detection top, scan tracker into window builder into sobel kernel
`timescale 1ns/1ps

module edge_detect_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  vsync,
    input  logic                  active_area,
    input  edge_pkg::rgb444_t     pixel,
    output logic                  edge_valid,
    output edge_pkg::edge_pixel_t edge_out
);
    import edge_pkg::*;

    // tracker to window builder
    logic       pix_stb;
    rgb444_t    pix_data;
    pixel_pos_t pix_pos;
    logic       frame_start;

    // window builder to kernel
    logic       win_stb;
    window_t    win;
    pixel_pos_t win_pos;

    scan_tracker u_scan_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .vsync       (vsync),
        .active_area (active_area),
        .pixel       (pixel),
        .pix_stb     (pix_stb),
        .pix_data    (pix_data),
        .pix_pos     (pix_pos),
        .frame_start (frame_start)
    );

    window_builder u_window_builder (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_stb     (pix_stb),
        .pix_data    (pix_data),
        .pix_pos     (pix_pos),
        .frame_start (frame_start),
        .win_stb     (win_stb),
        .win         (win),
        .win_pos     (win_pos)
    );

    sobel_kernel u_sobel_kernel (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .win_stb    (win_stb),
        .win        (win),
        .win_pos    (win_pos),
        .edge_valid (edge_valid),
        .edge_out   (edge_out)
    );

endmodule

// File: sobel_kernel.sv
// sobel kernel, two-stage gradient and magnitude pipeline with threshold and output enable
`timescale 1ns/1ps

module sobel_kernel (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  win_stb,
    input  edge_pkg::window_t     win,
    input  edge_pkg::pixel_pos_t  win_pos,
    output logic                  edge_valid,
    output edge_pkg::edge_pixel_t edge_out
);
    import edge_pkg::*;

    // weighted 1-2-1 tap sum, max 960
    function automatic logic [9:0] tap_sum(gray_t a, gray_t b, gray_t c);
        return {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
    endfunction

    logic [9:0]         left_sum;
    logic [9:0]         right_sum;
    logic [9:0]         top_sum;
    logic [9:0]         bottom_sum;

    // stage 1
    logic               stb_q;
    logic signed [10:0] gx_q;    // +-960
    logic signed [10:0] gy_q;
    pixel_pos_t         pos_q;

    magnitude_t         abs_x;
    magnitude_t         abs_y;
    magnitude_t         magnitude;

    assign left_sum   = tap_sum(win.p00, win.p10, win.p20);
    assign right_sum  = tap_sum(win.p02, win.p12, win.p22);
    assign top_sum    = tap_sum(win.p00, win.p01, win.p02);
    assign bottom_sum = tap_sum(win.p20, win.p21, win.p22);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stb_q <= 1'b0;
        end else begin
            stb_q <= win_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (win_stb) begin
            gx_q  <= $signed({1'b0, right_sum}) - $signed({1'b0, left_sum});
            gy_q  <= $signed({1'b0, bottom_sum}) - $signed({1'b0, top_sum});
            pos_q <= win_pos;
        end
    end

    // stage 2, |gx| + |gy| then threshold
    assign abs_x     = gx_q[10] ? magnitude_t'(-gx_q) : magnitude_t'(gx_q);
    assign abs_y     = gy_q[10] ? magnitude_t'(-gy_q) : magnitude_t'(gy_q);
    assign magnitude = abs_x + abs_y;  // cannot overflow, max 1920

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_valid <= 1'b0;
            edge_out   <= '0;
        end else begin
            edge_valid <= stb_q & enable;  // enable only gates here
            if (stb_q && enable) begin
                edge_out.pos   <= pos_q;
                edge_out.value <= edge_value(magnitude);
            end
        end
    end

endmodule

// File: window_builder.sv
// window builder, gray conversion plus two line buffers feeding a 3x3 register window
`timescale 1ns/1ps

module window_builder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pix_stb,
    input  edge_pkg::rgb444_t    pix_data,
    input  edge_pkg::pixel_pos_t pix_pos,
    input  logic                 frame_start,
    output logic                 win_stb,
    output edge_pkg::window_t    win,
    output edge_pkg::pixel_pos_t win_pos
);
    import edge_pkg::*;

    // gray stage
    gray_t      gray_q;
    logic       gray_stb;
    pixel_pos_t gray_pos;
    logic       gray_fs;   // frame_start kept in step with the gray stage

    // line buffers indexed by column
    gray_t      line0 [frame_width];  // row y-2
    gray_t      line1 [frame_width];  // row y-1

    gray_t      top_tap;
    gray_t      mid_tap;
    window_t    win_q;
    logic       full_window;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gray_stb <= 1'b0;
            gray_fs  <= 1'b0;
        end else begin
            gray_stb <= pix_stb;
            gray_fs  <= frame_start;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_stb) begin
            gray_q   <= rgb_to_gray(pix_data);
            gray_pos <= pix_pos;
        end
    end

    // old rows for this column
    assign top_tap = line0[gray_pos.x];
    assign mid_tap = line1[gray_pos.x];

    // each row moves up one buffer as the new row arrives
    always_ff @(posedge clk) begin
        if (gray_stb) begin
            line0[gray_pos.x] <= mid_tap;
            line1[gray_pos.x] <= gray_q;
        end
    end

    // two columns of history needed on both axes
    assign full_window = (gray_pos.x >= 9'd2) && (gray_pos.y >= 9'd2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_q <= '0;
        end else if (gray_fs) begin
            win_q <= '0;  // nothing survives into the next frame
        end else if (gray_stb) begin
            // top row
            win_q.p00 <= win_q.p01;
            win_q.p01 <= win_q.p02;
            win_q.p02 <= top_tap;
            // middle row
            win_q.p10 <= win_q.p11;
            win_q.p11 <= win_q.p12;
            win_q.p12 <= mid_tap;
            // bottom row, newest pixel
            win_q.p20 <= win_q.p21;
            win_q.p21 <= win_q.p22;
            win_q.p22 <= gray_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_stb <= 1'b0;
        end else begin
            win_stb <= gray_stb & full_window;
        end
    end

    // centre sits one column left and one row up
    always_ff @(posedge clk) begin
        if (gray_stb) begin
            win_pos.x <= gray_pos.x - 9'd1;
            win_pos.y <= gray_pos.y - 9'd1;
        end
    end

    assign win = win_q;

endmodule

// File: scan_tracker.sv
// scan tracker, finds frame starts and gives every active pixel its column and row
`timescale 1ns/1ps

module scan_tracker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                vsync,
    input  logic                active_area,
    input  edge_pkg::rgb444_t   pixel,
    output logic                pix_stb,
    output edge_pkg::rgb444_t   pix_data,
    output edge_pkg::pixel_pos_t pix_pos,
    output logic                frame_start
);
    import edge_pkg::*;

    logic   vsync_q;
    logic   active_q;
    coord_t col_cnt;     // next column to assign
    coord_t row_cnt;
    logic   vsync_rise;
    logic   line_full;
    logic   new_line;
    logic   accept;

    assign vsync_rise = vsync & ~vsync_q;
    assign line_full  = (col_cnt == frame_width);
    // first pixel after a gap, once the current line is complete
    assign new_line   = active_area & ~active_q & line_full;

    // drop anything past the last column or the last row
    assign accept = active_area & ~vsync_rise &
                    (new_line ? (row_cnt != frame_height - 9'd1) : ~line_full);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_q     <= 1'b0;
            active_q    <= 1'b0;
            frame_start <= 1'b0;
            pix_stb     <= 1'b0;
            col_cnt     <= '0;
            row_cnt     <= '0;
        end else begin
            vsync_q     <= vsync;
            active_q    <= active_area;
            frame_start <= vsync_rise;
            pix_stb     <= accept;
            if (vsync_rise) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (accept) begin
                if (new_line) begin
                    col_cnt <= 9'd1;  // this pixel takes column 0
                    row_cnt <= row_cnt + 9'd1;
                end else begin
                    col_cnt <= col_cnt + 9'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pix_data  <= pixel;
            pix_pos.x <= new_line ? '0 : col_cnt;
            pix_pos.y <= new_line ? row_cnt + 9'd1 : row_cnt;
        end
    end

endmodule

// File: edge_pkg.sv
// edge detection package with frame constants, pixel types and the gray and threshold math
package edge_pkg;

    typedef logic [8:0]  coord_t;      // column or row
    typedef logic [11:0] rgb444_t;     // r[11:8] g[7:4] b[3:0]
    typedef logic [7:0]  gray_t;       // 4*(r + 2g + b), max 240
    typedef logic [10:0] magnitude_t;  // |gx| + |gy|, max 1920

    // active frame size
    localparam coord_t frame_width  = 9'd320;
    localparam coord_t frame_height = 9'd240;

    localparam magnitude_t strong_threshold = 11'd25;  // above this -> white
    localparam magnitude_t noise_threshold  = 11'd12;  // at or below this -> black

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    // row 0 is the oldest line, column 0 the leftmost pixel
    typedef struct packed {
        gray_t p00;
        gray_t p01;
        gray_t p02;
        gray_t p10;
        gray_t p11;
        gray_t p12;
        gray_t p20;
        gray_t p21;
        gray_t p22;
    } window_t;

    typedef struct packed {
        pixel_pos_t pos;
        gray_t      value;
    } edge_pixel_t;

    // luma approximation, green weighted twice
    function automatic gray_t rgb_to_gray(rgb444_t rgb);
        logic [5:0] sum;
        sum = {2'b00, rgb[11:8]} + {1'b0, rgb[7:4], 1'b0} + {2'b00, rgb[3:0]};
        return {sum, 2'b00};
    endfunction

    // two-level threshold on the gradient magnitude
    function automatic gray_t edge_value(magnitude_t mag);
        if (mag > strong_threshold) begin
            return 8'hff;
        end else if (mag > noise_threshold) begin
            return mag[7:0];  // mid band passes through, 13..25
        end
        return 8'h00;
    endfunction

endpackage
